//--- design/periph_macros.svh
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// **********************************************************
// Bus and pin widths
// **********************************************************
`define PERIPH_ADDR_W        8
`define PERIPH_DATA_W        32
`define GPIO_W               16

// Region code in address bits 7 to 6
`define REGION_GPIO          2'b00
`define REGION_SYSCON        2'b01

// GPIO word offsets
`define GPIO_REG_IN          4'd0
`define GPIO_REG_OUT         4'd1
`define GPIO_REG_OE          4'd2
`define GPIO_REG_IRQ_EN      4'd3
`define GPIO_REG_IRQ_STAT    4'd4

// System controller word offsets
`define SYS_REG_ID           4'd0
`define SYS_REG_MTIME_LO     4'd1
`define SYS_REG_MTIME_HI     4'd2
`define SYS_REG_MTIMECMP_LO  4'd3
`define SYS_REG_MTIMECMP_HI  4'd4
`define SYS_REG_SW_IRQ       4'd5

`define SYS_ID_VALUE         32'h5357_0001

`endif

//--- design/periph_pkg.sv
package periph_pkg;

`include "periph_macros.svh"

   // **********************************************************
   // Plain vector types
   // **********************************************************
   typedef logic [`PERIPH_ADDR_W-1:0] wb_addr_t;
   typedef logic [`PERIPH_DATA_W-1:0] wb_data_t;
   typedef logic [3:0]                reg_idx_t;
   typedef logic [`GPIO_W-1:0]        gpio_t;
   typedef logic [63:0]               mtime_t;

   // **********************************************************
   // Bus and interrupt bundles
   // **********************************************************

   // Host to slave, Wishbone classic
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   // Slave to host
   typedef struct packed {
      logic     ack;
      logic     err;
      wb_data_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic gpio;
      logic timer;
      logic sw3;
      logic sw4;
   } irq_vec_t;

endpackage

//--- design/wb_gpio.sv
`timescale 1ns/100ps

`include "periph_macros.svh"

module wb_gpio import periph_pkg::*; (
   input  logic    i_clk,
   input  logic    i_reset,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp,
   input  gpio_t   i_gpio_in,
   output gpio_t   o_gpio_out,
   output gpio_t   o_gpio_oe,
   output logic    o_irq
);

   gpio_t    sync_q1;
   gpio_t    sync_q2;
   gpio_t    prev_q;
   gpio_t    out_q;
   gpio_t    oe_q;
   gpio_t    irq_en_q;
   gpio_t    irq_stat_q;
   gpio_t    rise;
   gpio_t    stat_clr;
   logic     access;
   logic     wr_en;
   logic     ack_q;
   reg_idx_t reg_idx;
   wb_data_t rd_data;
   wb_data_t rd_data_q;

   // One access per request, the ack cycle is never taken as a new one
   assign access  = i_req.cyc & i_req.stb & ~ack_q;
   assign wr_en   = access & i_req.we;
   assign reg_idx = i_req.adr[5:2];

   // **********************************************************
   // Input synchroniser and edge detect
   // **********************************************************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         prev_q  <= '0;
      end else begin
         sync_q1 <= i_gpio_in;
         sync_q2 <= sync_q1;
         prev_q  <= sync_q2;
      end
   end

   assign rise     = sync_q2 & ~prev_q & irq_en_q;
   assign stat_clr = (wr_en && reg_idx == `GPIO_REG_IRQ_STAT) ? i_req.dat[`GPIO_W-1:0] : '0;

   // **********************************************************
   // Register file
   // **********************************************************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_q      <= '0;
         oe_q       <= '0;
         irq_en_q   <= '0;
         irq_stat_q <= '0;
         ack_q      <= 1'b0;
      end else begin
         ack_q      <= access;
         // New edge wins over a clear in the same cycle
         irq_stat_q <= (irq_stat_q & ~stat_clr) | rise;
         if (wr_en) begin
            case (reg_idx)
               `GPIO_REG_OUT:    out_q    <= i_req.dat[`GPIO_W-1:0];
               `GPIO_REG_OE:     oe_q     <= i_req.dat[`GPIO_W-1:0];
               `GPIO_REG_IRQ_EN: irq_en_q <= i_req.dat[`GPIO_W-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (reg_idx)
         `GPIO_REG_IN:       rd_data = wb_data_t'(sync_q2);
         `GPIO_REG_OUT:      rd_data = wb_data_t'(out_q);
         `GPIO_REG_OE:       rd_data = wb_data_t'(oe_q);
         `GPIO_REG_IRQ_EN:   rd_data = wb_data_t'(irq_en_q);
         `GPIO_REG_IRQ_STAT: rd_data = wb_data_t'(irq_stat_q);
         default:            rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         rd_data_q <= rd_data;
      end
   end

   assign o_rsp      = '{ack: ack_q, err: 1'b0, dat: rd_data_q};
   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_irq      = |irq_stat_q;

   ack_single_cycle: assert property (
      @(posedge i_clk) disable iff (i_reset) o_rsp.ack |=> !o_rsp.ack
   );

endmodule

//--- design/wb_syscon_timer.sv
`timescale 1ns/100ps

`include "periph_macros.svh"

module wb_syscon_timer import periph_pkg::*; (
   input  logic    i_clk,
   input  logic    i_reset,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp,
   output logic    o_timer_irq,
   output logic    o_sw_irq3,
   output logic    o_sw_irq4
);

   mtime_t   mtime_q;
   mtime_t   mtimecmp_q;
   logic     timer_irq_q;
   logic     sw_irq3_q;
   logic     sw_irq4_q;
   logic     access;
   logic     wr_en;
   logic     ack_q;
   reg_idx_t reg_idx;
   wb_data_t rd_data;
   wb_data_t rd_data_q;

   assign access  = i_req.cyc & i_req.stb & ~ack_q;
   assign wr_en   = access & i_req.we;
   assign reg_idx = i_req.adr[5:2];

   // **********************************************************
   // Machine timer
   // **********************************************************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         timer_irq_q <= 1'b0;
      end else begin
         mtime_q     <= mtime_q + 64'd1;
         timer_irq_q <= (mtime_q >= mtimecmp_q);
         if (wr_en && reg_idx == `SYS_REG_MTIMECMP_LO) begin
            mtimecmp_q[31:0] <= i_req.dat;
         end
         if (wr_en && reg_idx == `SYS_REG_MTIMECMP_HI) begin
            mtimecmp_q[63:32] <= i_req.dat;
         end
      end
   end

   // **********************************************************
   // Software interrupts and bus response
   // **********************************************************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         sw_irq3_q <= 1'b0;
         sw_irq4_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= access;
         if (wr_en && reg_idx == `SYS_REG_SW_IRQ) begin
            sw_irq3_q <= i_req.dat[0];
            sw_irq4_q <= i_req.dat[1];
         end
      end
   end

   // ID and mtime are read only
   always_comb begin
      case (reg_idx)
         `SYS_REG_ID:          rd_data = `SYS_ID_VALUE;
         `SYS_REG_MTIME_LO:    rd_data = mtime_q[31:0];
         `SYS_REG_MTIME_HI:    rd_data = mtime_q[63:32];
         `SYS_REG_MTIMECMP_LO: rd_data = mtimecmp_q[31:0];
         `SYS_REG_MTIMECMP_HI: rd_data = mtimecmp_q[63:32];
         `SYS_REG_SW_IRQ:      rd_data = {30'd0, sw_irq4_q, sw_irq3_q};
         default:              rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         rd_data_q <= rd_data;
      end
   end

   assign o_rsp       = '{ack: ack_q, err: 1'b0, dat: rd_data_q};
   assign o_timer_irq = timer_irq_q;
   assign o_sw_irq3   = sw_irq3_q;
   assign o_sw_irq4   = sw_irq4_q;

   // Compare disabled for a full cycle means no pending timer interrupt
   timer_off_when_cmp_max: assert property (
      @(posedge i_clk) disable iff (i_reset)
      (mtimecmp_q == '1) && $past(mtimecmp_q == '1) |-> !o_timer_irq
   );

endmodule

//--- design/wb_periph_fabric.sv
`timescale 1ns/100ps

`include "periph_macros.svh"

module wb_periph_fabric import periph_pkg::*; (
   input  logic     i_clk,
   input  logic     i_reset,
   input  wb_req_t  i_wb_req,
   output wb_rsp_t  o_wb_rsp,
   output wb_req_t  o_gpio_req,
   input  wb_rsp_t  i_gpio_rsp,
   output wb_req_t  o_sys_req,
   input  wb_rsp_t  i_sys_rsp,
   input  logic     i_gpio_irq,
   input  logic     i_timer_irq,
   input  logic     i_sw_irq3,
   input  logic     i_sw_irq4,
   output irq_vec_t o_irq
);

   logic [1:0] region;
   logic       sel_gpio;
   logic       sel_sys;
   logic       unmapped;
   logic       err_q;
   wb_data_t   rsp_dat;

   // **********************************************************
   // Region decode
   // **********************************************************
   assign region   = i_wb_req.adr[`PERIPH_ADDR_W-1 -: 2];
   assign sel_gpio = (region == `REGION_GPIO);
   assign sel_sys  = (region == `REGION_SYSCON);
   assign unmapped = ~sel_gpio & ~sel_sys;

   always_comb begin
      o_gpio_req     = i_wb_req;
      o_gpio_req.stb = i_wb_req.stb & sel_gpio;
      o_sys_req      = i_wb_req;
      o_sys_req.stb  = i_wb_req.stb & sel_sys;
   end

   // Error responder, one pulse per request
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         err_q <= 1'b0;
      end else begin
         err_q <= i_wb_req.cyc & i_wb_req.stb & unmapped & ~err_q;
      end
   end

   // **********************************************************
   // Response and interrupt merge
   // **********************************************************
   always_comb begin
      if (i_gpio_rsp.ack) begin
         rsp_dat = i_gpio_rsp.dat;
      end else if (i_sys_rsp.ack) begin
         rsp_dat = i_sys_rsp.dat;
      end else begin
         rsp_dat = '0;
      end
   end

   assign o_wb_rsp.ack = i_gpio_rsp.ack | i_sys_rsp.ack;
   assign o_wb_rsp.err = err_q | i_gpio_rsp.err | i_sys_rsp.err;
   assign o_wb_rsp.dat = rsp_dat;

   assign o_irq = '{gpio: i_gpio_irq, timer: i_timer_irq, sw3: i_sw_irq3, sw4: i_sw_irq4};

   ack_err_exclusive: assert property (
      @(posedge i_clk) disable iff (i_reset) !(o_wb_rsp.ack && o_wb_rsp.err)
   );

   // Holds for every slave behind the fabric, not only the err responder
   rsp_single_cycle: assert property (
      @(posedge i_clk) disable iff (i_reset)
      (o_wb_rsp.ack || o_wb_rsp.err) |=> !(o_wb_rsp.ack || o_wb_rsp.err)
   );

endmodule

//--- design/periph_subsystem_top.sv
`timescale 1ns/100ps

module periph_subsystem_top import periph_pkg::*; (
   input  logic     i_clk,
   input  logic     i_reset,
   input  wb_req_t  i_wb_req,
   output wb_rsp_t  o_wb_rsp,
   input  gpio_t    i_gpio_in,
   output gpio_t    o_gpio_out,
   output gpio_t    o_gpio_oe,
   output irq_vec_t o_irq
);

   wb_req_t gpio_req;
   wb_rsp_t gpio_rsp;
   wb_req_t sys_req;
   wb_rsp_t sys_rsp;
   logic    gpio_irq;
   logic    timer_irq;
   logic    sw_irq3;
   logic    sw_irq4;

   wb_periph_fabric fabric (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_wb_req    (i_wb_req),
      .o_wb_rsp    (o_wb_rsp),
      .o_gpio_req  (gpio_req),
      .i_gpio_rsp  (gpio_rsp),
      .o_sys_req   (sys_req),
      .i_sys_rsp   (sys_rsp),
      .i_gpio_irq  (gpio_irq),
      .i_timer_irq (timer_irq),
      .i_sw_irq3   (sw_irq3),
      .i_sw_irq4   (sw_irq4),
      .o_irq       (o_irq)
   );

   // Pads are built at board level from data and output enable
   wb_gpio gpio (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_req      (gpio_req),
      .o_rsp      (gpio_rsp),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_irq      (gpio_irq)
   );

   wb_syscon_timer syscon (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_req       (sys_req),
      .o_rsp       (sys_rsp),
      .o_timer_irq (timer_irq),
      .o_sw_irq3   (sw_irq3),
      .o_sw_irq4   (sw_irq4)
   );

endmodule

//--- verification/periph_checker.sv
`timescale 1ns/100ps

module periph_checker import periph_pkg::*; (
   input  logic            i_clk,
   input  logic            i_reset,
   input  wb_req_t         i_wb_req,
   input  wb_rsp_t         i_wb_rsp,
   input  gpio_t           i_gpio_out,
   input  gpio_t           i_gpio_oe,
   input  irq_vec_t        i_irq,
   input  logic            i_check,
   input  logic [8*16-1:0] i_name,
   input  logic            i_exp_err,
   input  wb_data_t        i_exp_dat,
   input  logic [1:0]      i_mode,
   input  irq_vec_t        i_exp_irq,
   input  gpio_t           i_exp_out,
   input  gpio_t           i_exp_oe,
   input  logic            i_done,
   output int              o_test_count,
   output int              o_fail_count
);

   localparam logic [1:0] MODE_EXACT   = 2'd0;
   localparam logic [1:0] MODE_GT_PREV = 2'd2;

   logic     rsp_seen;
   logic     wait_rsp;
   logic     got_rsp;
   logic     got_ack;
   logic     got_err;
   logic     lat_bad;
   wb_data_t got_dat;
   wb_data_t last_dat;
   int       test_count = 0;
   int       fail_count = 0;

   assign o_test_count = test_count;
   assign o_fail_count = fail_count;

   function automatic string rsp_kind(input logic ack, input logic err);
      if (ack && err) begin
         return "ack and err";
      end
      return err ? "err" : "ack";
   endfunction

   // First mismatch of a test decides its report line
   task compare_test;
      logic bad;
      bad = 1'b1;
      test_count++;
      if (!got_rsp) begin
         $display("%0s: no bus response was seen", i_name);
      end else if (lat_bad) begin
         $display("%0s: response did not come exactly one cycle after the request", i_name);
      end else if (got_err !== i_exp_err || got_ack !== !i_exp_err) begin
         $display("Error %0s: response expected %0s actual %0s", i_name,
                  rsp_kind(!i_exp_err, i_exp_err), rsp_kind(got_ack, got_err));
      end else if (i_mode == MODE_EXACT && got_dat !== i_exp_dat) begin
         $display("Error %0s: read data expected %h actual %h", i_name, i_exp_dat, got_dat);
      end else if (i_mode == MODE_GT_PREV && !(got_dat > last_dat)) begin
         $display("Error %0s: read data expected above %h actual %h", i_name, last_dat, got_dat);
      end else if (i_irq !== i_exp_irq) begin
         $display("Error %0s: o_irq expected %b actual %b", i_name, i_exp_irq, i_irq);
      end else if (i_gpio_out !== i_exp_out) begin
         $display("Error %0s: o_gpio_out expected %h actual %h", i_name, i_exp_out, i_gpio_out);
      end else if (i_gpio_oe !== i_exp_oe) begin
         $display("Error %0s: o_gpio_oe expected %h actual %h", i_name, i_exp_oe, i_gpio_oe);
      end else begin
         bad = 1'b0;
         $display("ok    %0s", i_name);
      end
      if (bad) begin
         fail_count++;
      end
   endtask

   // **********************************************************
   // Bus monitor and per-test compare
   // **********************************************************
   always @(posedge i_clk) begin
      if (i_reset) begin
         wait_rsp <= 1'b0;
         got_rsp  <= 1'b0;
         lat_bad  <= 1'b0;
         last_dat <= '0;
      end else begin
         rsp_seen = i_wb_rsp.ack | i_wb_rsp.err;
         if (rsp_seen) begin
            // A response must follow the first request cycle directly
            if (!wait_rsp) begin
               lat_bad <= 1'b1;
            end
            got_rsp <= 1'b1;
            got_ack <= i_wb_rsp.ack;
            got_err <= i_wb_rsp.err;
            got_dat <= i_wb_rsp.dat;
         end else if (wait_rsp) begin
            lat_bad <= 1'b1;
         end
         wait_rsp <= i_wb_req.cyc & i_wb_req.stb & ~rsp_seen & ~wait_rsp;
         if (i_check) begin
            compare_test();
            got_rsp  <= 1'b0;
            lat_bad  <= 1'b0;
            last_dat <= got_dat;
         end
         if (i_done) begin
            $display("Tests run %0d, passed %0d, failed %0d", test_count,
                     test_count - fail_count, fail_count);
         end
      end
   end

endmodule

//--- verification/tb_periph_top.sv
`timescale 1ns/100ps

`include "periph_macros.svh"

module tb_periph_top import periph_pkg::*; ();

   localparam int N_TESTS        = 25;
   localparam int RESET_CYCLES   = 8;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 10 * N_TESTS + 50;

   localparam logic [1:0] MODE_EXACT   = 2'd0;
   localparam logic [1:0] MODE_IGNORE  = 2'd1;
   localparam logic [1:0] MODE_GT_PREV = 2'd2;

   typedef struct packed {
      logic [8*16-1:0] name;
      logic            we;
      wb_addr_t        adr;
      wb_data_t        wdat;
      gpio_t           gpio_in;
      logic            exp_err;
      wb_data_t        exp_dat;
      logic [1:0]      mode;
      irq_vec_t        exp_irq;
      gpio_t           exp_out;
      gpio_t           exp_oe;
   } test_t;

   logic        i_clk;
   logic        i_reset;
   wb_req_t     i_wb_req;
   wb_rsp_t     o_wb_rsp;
   gpio_t       i_gpio_in;
   gpio_t       o_gpio_out;
   gpio_t       o_gpio_oe;
   irq_vec_t    o_irq;
   logic        check;
   logic        done;
   test_t       exp_q;
   test_t       tests [N_TESTS];
   int          n_loaded = 0;
   int          cycle_count = 0;
   int          test_count;
   int          fail_count;
   gpio_t       pat_out;
   gpio_t       pat_oe;

   periph_subsystem_top i_dut (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_wb_req   (i_wb_req),
      .o_wb_rsp   (o_wb_rsp),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_irq      (o_irq)
   );

   periph_checker i_chk (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_wb_req     (i_wb_req),
      .i_wb_rsp     (o_wb_rsp),
      .i_gpio_out   (o_gpio_out),
      .i_gpio_oe    (o_gpio_oe),
      .i_irq        (o_irq),
      .i_check      (check),
      .i_name       (exp_q.name),
      .i_exp_err    (exp_q.exp_err),
      .i_exp_dat    (exp_q.exp_dat),
      .i_mode       (exp_q.mode),
      .i_exp_irq    (exp_q.exp_irq),
      .i_exp_out    (exp_q.exp_out),
      .i_exp_oe     (exp_q.exp_oe),
      .i_done       (done),
      .o_test_count (test_count),
      .o_fail_count (fail_count)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic wb_addr_t gpio_adr(input reg_idx_t idx);
      return {`REGION_GPIO, idx, 2'b00};
   endfunction

   function automatic wb_addr_t sys_adr(input reg_idx_t idx);
      return {`REGION_SYSCON, idx, 2'b00};
   endfunction

   task add_test(input logic [8*16-1:0] name, input logic we, input wb_addr_t adr,
                 input wb_data_t wdat, input gpio_t gin, input logic exp_err,
                 input wb_data_t exp_dat, input logic [1:0] mode, input irq_vec_t irq,
                 input gpio_t out, input gpio_t oe);
      tests[n_loaded] = {name, we, adr, wdat, gin, exp_err, exp_dat, mode, irq, out, oe};
      n_loaded++;
   endtask

   // One Wishbone classic access, request held until ack or err
   task automatic run_access(input test_t t);
      @(posedge i_clk);
      #1;
      i_wb_req.cyc = 1'b1;
      i_wb_req.stb = 1'b1;
      i_wb_req.we  = t.we;
      i_wb_req.adr = t.adr;
      i_wb_req.dat = t.wdat;
      @(posedge i_clk);
      @(posedge i_clk);
      while (!(o_wb_rsp.ack || o_wb_rsp.err)) begin
         @(posedge i_clk);
      end
      #1;
      i_wb_req = '0;
   endtask

   initial begin
      i_reset   = 1'b1;
      i_wb_req  = '0;
      i_gpio_in = '0;
      check     = 1'b0;
      done      = 1'b0;
      exp_q     = '0;
      void'($urandom(32'had9d));
      pat_out   = gpio_t'($urandom());
      pat_oe    = gpio_t'($urandom());

      // ******************************************************
      // Stimulus table
      // ******************************************************
      add_test("reset_out_rd", 1'b0, gpio_adr(`GPIO_REG_OUT), 32'h0, 16'h0,
               1'b0, 32'h0, MODE_EXACT, 4'b0000, 16'h0, 16'h0);
      add_test("reset_id_rd", 1'b0, sys_adr(`SYS_REG_ID), 32'h0, 16'h0,
               1'b0, `SYS_ID_VALUE, MODE_EXACT, 4'b0000, 16'h0, 16'h0);
      add_test("out_wr", 1'b1, gpio_adr(`GPIO_REG_OUT), {16'h0, pat_out}, 16'h0,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, 16'h0);
      add_test("out_rd", 1'b0, gpio_adr(`GPIO_REG_OUT), 32'h0, 16'h0,
               1'b0, {16'h0, pat_out}, MODE_EXACT, 4'b0000, pat_out, 16'h0);
      add_test("oe_wr", 1'b1, gpio_adr(`GPIO_REG_OE), {16'h0, pat_oe}, 16'h0,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("oe_rd", 1'b0, gpio_adr(`GPIO_REG_OE), 32'h0, 16'h0,
               1'b0, {16'h0, pat_oe}, MODE_EXACT, 4'b0000, pat_out, pat_oe);
      add_test("in_rd", 1'b0, gpio_adr(`GPIO_REG_IN), 32'h0, 16'ha5c3,
               1'b0, 32'h0000_a5c3, MODE_EXACT, 4'b0000, pat_out, pat_oe);
      add_test("irq_en_wr", 1'b1, gpio_adr(`GPIO_REG_IRQ_EN), 32'h1, 16'h0,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      // Bit 0 rises with its enable set, bit 1 rises masked
      add_test("edge_enabled", 1'b0, gpio_adr(`GPIO_REG_IRQ_STAT), 32'h0, 16'h1,
               1'b0, 32'h1, MODE_EXACT, 4'b1000, pat_out, pat_oe);
      add_test("edge_masked", 1'b0, gpio_adr(`GPIO_REG_IRQ_STAT), 32'h0, 16'h3,
               1'b0, 32'h1, MODE_EXACT, 4'b1000, pat_out, pat_oe);
      add_test("stat_clear", 1'b1, gpio_adr(`GPIO_REG_IRQ_STAT), 32'h1, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("stat_rd", 1'b0, gpio_adr(`GPIO_REG_IRQ_STAT), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_EXACT, 4'b0000, pat_out, pat_oe);
      add_test("mtime_rd_first", 1'b0, sys_adr(`SYS_REG_MTIME_LO), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("mtime_rd_second", 1'b0, sys_adr(`SYS_REG_MTIME_LO), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_GT_PREV, 4'b0000, pat_out, pat_oe);
      add_test("cmp_lo_zero", 1'b1, sys_adr(`SYS_REG_MTIMECMP_LO), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("cmp_hi_zero", 1'b1, sys_adr(`SYS_REG_MTIMECMP_HI), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0100, pat_out, pat_oe);
      add_test("cmp_lo_ones", 1'b1, sys_adr(`SYS_REG_MTIMECMP_LO), 32'hffff_ffff, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("cmp_hi_ones", 1'b1, sys_adr(`SYS_REG_MTIMECMP_HI), 32'hffff_ffff, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("sw_irq3_set", 1'b1, sys_adr(`SYS_REG_SW_IRQ), 32'h1, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0010, pat_out, pat_oe);
      add_test("sw_irq4_set", 1'b1, sys_adr(`SYS_REG_SW_IRQ), 32'h2, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0001, pat_out, pat_oe);
      add_test("sw_irq_clear", 1'b1, sys_adr(`SYS_REG_SW_IRQ), 32'h0, 16'h3,
               1'b0, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      // Unmapped regions alias GPIO_REG_OUT and SYS_REG_SW_IRQ offsets
      add_test("region2_wr", 1'b1, 8'h84, {16'h0, ~pat_out}, 16'h3,
               1'b1, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("region3_wr", 1'b1, 8'hd4, 32'h3, 16'h3,
               1'b1, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);
      add_test("out_after_err", 1'b0, gpio_adr(`GPIO_REG_OUT), 32'h0, 16'h3,
               1'b0, {16'h0, pat_out}, MODE_EXACT, 4'b0000, pat_out, pat_oe);
      add_test("region2_rd", 1'b0, 8'h80, 32'h0, 16'h3,
               1'b1, 32'h0, MODE_IGNORE, 4'b0000, pat_out, pat_oe);

      repeat (RESET_CYCLES) @(posedge i_clk);
      #1;
      i_reset = 1'b0;

      // ******************************************************
      // Apply the table
      // ******************************************************
      for (int i = 0; i < n_loaded; i++) begin
         @(posedge i_clk);
         #1;
         i_gpio_in = tests[i].gpio_in;
         repeat (4) @(posedge i_clk);
         run_access(tests[i]);
         exp_q = tests[i];
         check = 1'b1;
         @(posedge i_clk);
         #1;
         check = 1'b0;
      end

      done = 1'b1;
      @(posedge i_clk);
      #1;
      done = 1'b0;
      @(posedge i_clk);
      #1;
      if (fail_count == 0 && test_count == N_TESTS) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
design/periph_pkg.sv
design/wb_gpio.sv
design/wb_syscon_timer.sv
design/wb_periph_fabric.sv
design/periph_subsystem_top.sv
verification/periph_checker.sv
verification/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/periph_pkg.sv
      - design/wb_gpio.sv
      - design/wb_syscon_timer.sv
      - design/wb_periph_fabric.sv
      - design/periph_subsystem_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/periph_checker.sv
      - verification/tb_periph_top.sv
